/* Makefile */
# Verilator build and run for the instruction cache.

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only -Wall --timing
TOP       := icache_tb
FILELIST  := icache_top.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "Testbench passed" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* icache_top.f */
src/icache_geom_pkg.sv
src/icache_fsm_pkg.sv
src/icache_tag_store.sv
src/icache_line_store.sv
src/icache_fill_ctrl.sv
src/icache_top.sv
sim/icache_props.sv
sim/icache_tb.sv

/* sim/icache_props.sv */
`timescale 1ns/1ns

module icache_props
        import icache_geom_pkg::*;
(
        input  logic    i_clk,                  // DUT clock.
        input  logic    i_reset,                // DUT reset.
        input  logic    i_rsp_valid,            // Response strobe.
        input  logic    i_busy,
        input  logic    i_ram_rd_en,
        input  addr_t   i_ram_address,
        input  logic    i_ram_done
);

        // --------------------
        // Reset state
        // --------------------
        a_reset_quiet: assert property (@(posedge i_clk)
                i_reset |=> (!i_rsp_valid && !i_busy && !i_ram_rd_en))
                else $error("Outputs not idle after reset.");

        // RAM request held until done.
        a_ram_hold: assert property (@(posedge i_clk) disable iff (i_reset)
                (i_ram_rd_en && !i_ram_done) |=> (i_ram_rd_en && $stable(i_ram_address)))
                else $error("RAM request dropped or moved before done.");

        a_no_overlap: assert property (@(posedge i_clk) disable iff (i_reset)
                !(i_rsp_valid && i_ram_rd_en))
                else $error("Response and RAM read in the same cycle.");

endmodule

bind icache_top icache_props u_props (
        .i_clk          (i_clk),
        .i_reset        (i_reset),
        .i_rsp_valid    (o_fetch_valid),
        .i_busy         (o_busy),
        .i_ram_rd_en    (o_ram_rd_en),
        .i_ram_address  (o_ram_address),
        .i_ram_done     (i_ram_done)
);

/* sim/icache_tb.sv */
`timescale 1ns/1ns

module icache_tb
        import icache_geom_pkg::*;
();

        localparam int LINE_COUNT = 16;
        localparam int MEM_WORDS  = 1024;       // RAM model size.
        localparam int REQ_COUNT  = 400;
        localparam int WAIT_LIMIT = 200;        // Cycles per response.

        logic   i_clk;
        logic   i_reset;
        logic   i_fetch_valid;
        addr_t  i_fetch_addr;
        logic   i_cache_en;
        logic   i_cache_inv;
        logic   i_ram_done;
        word_t  i_ram_rd_data;
        logic   o_fetch_valid;
        word_t  o_fetch_data;
        logic   o_busy;
        logic   o_ram_rd_en;
        addr_t  o_ram_address;

        word_t          ram_mem [MEM_WORDS];    // RAM contents.
        logic [23:0]    model_tag [LINE_COUNT]; // Tag per line.
        logic           model_valid [LINE_COUNT];
        logic           model_en;               // Enable as the model sees it.
        addr_t          exp_ram_q [$];          // Expected RAM addresses.
        word_t          exp_data_q [$];         // Expected response data.
        addr_t          ram_exp_addr;
        int             ram_wait;               // Cycles left to done.
        int             errors;

        icache_top #(.LINE_COUNT(LINE_COUNT)) u_dut (
                .i_clk          (i_clk),
                .i_reset        (i_reset),
                .i_fetch_valid  (i_fetch_valid),
                .i_fetch_addr   (i_fetch_addr),
                .i_cache_en     (i_cache_en),
                .i_cache_inv    (i_cache_inv),
                .i_ram_done     (i_ram_done),
                .i_ram_rd_data  (i_ram_rd_data),
                .o_fetch_valid  (o_fetch_valid),
                .o_fetch_data   (o_fetch_data),
                .o_busy         (o_busy),
                .o_ram_rd_en    (o_ram_rd_en),
                .o_ram_address  (o_ram_address)
        );

        initial
        begin
                i_clk = 1'b0;
                forever #50 i_clk = ~i_clk;
        end

        // --------------------
        // Failure handling
        // --------------------
        task automatic abort_run(input string why);
                $display("%s", why);
                $display("Testbench failed");
                $fatal(1, "Run stopped.");
        endtask

        task automatic check_value(input string name, input logic [31:0] exp,
                                   input logic [31:0] act);
                if (exp !== act)
                begin
                        $display("Error %s: expected %h, actual %h", name, exp, act);
                        errors = errors + 1;
                        abort_run("Value mismatch.");
                end
        endtask

        // --------------------
        // RAM model
        // --------------------
        always @(posedge i_clk)
        begin
                if (i_reset)
                begin
                        i_ram_done <= 1'b0;
                        ram_wait = 0;
                end
                else if (i_ram_done)
                        i_ram_done <= 1'b0;             // Next read starts after done.
                else if (o_ram_rd_en)
                begin
                        if (ram_wait == 0)
                        begin
                                if (exp_ram_q.size() == 0)
                                        abort_run("RAM read issued when none was expected.");
                                ram_exp_addr = exp_ram_q.pop_front();
                                check_value("ram address", ram_exp_addr, o_ram_address);
                                ram_wait = 1 + int'($urandom % 4);      // 1 to 4 cycles.
                        end
                        if (ram_wait == 1)
                        begin
                                i_ram_done    <= 1'b1;
                                i_ram_rd_data <= ram_mem[o_ram_address[11:2]];
                        end
                        ram_wait = ram_wait - 1;
                end
        end

        // One request, from strobe to response.
        task automatic run_request(input addr_t addr);
                int             idx;
                logic [23:0]    tag;
                logic           hit;
                int             cycles;
                idx = int'(addr[7:4]);
                tag = addr[31:8];
                hit = model_en && model_valid[idx] && (model_tag[idx] == tag);
                if (!hit && model_en)
                begin
                        for (int w = 0; w < 4; w++)
                                exp_ram_q.push_back({addr[31:4], 4'b0000} | addr_t'(w * 4));
                        model_valid[idx] = 1'b1;        // Line now cached.
                        model_tag[idx]   = tag;
                end
                else if (!hit)
                        exp_ram_q.push_back(addr);      // Uncached single read.
                exp_data_q.push_back(ram_mem[addr[11:2]]);
                i_fetch_valid <= 1'b1;
                i_fetch_addr  <= addr;
                @(posedge i_clk);
                i_fetch_valid <= 1'b0;
                @(negedge i_clk);
                cycles = 1;
                while (!o_fetch_valid)
                begin
                        check_value("busy while waiting", 1, o_busy);
                        if (cycles >= WAIT_LIMIT)
                                abort_run("Timed out waiting for a fetch response.");
                        @(negedge i_clk);
                        cycles = cycles + 1;
                end
                check_value("busy at response", 0, o_busy);
                check_value("fetch data", exp_data_q.pop_front(), o_fetch_data);
                if (hit)
                        check_value("hit latency", 1, cycles);
                check_value("ram reads left", 0, exp_ram_q.size());
        endtask

        // --------------------
        // Main sequence
        // --------------------
        initial
        begin
                int     r;
                addr_t  addr;
                void'($urandom(38));
                errors     = 0;
                for (int i = 0; i < MEM_WORDS; i++)
                        ram_mem[i] = $urandom;
                for (int i = 0; i < LINE_COUNT; i++)
                begin
                        model_valid[i] = 1'b0;
                        model_tag[i]   = '0;
                end
                model_en      = 1'b1;
                i_reset       = 1'b1;
                i_fetch_valid = 1'b0;
                i_fetch_addr  = '0;
                i_cache_en    = 1'b1;
                i_cache_inv   = 1'b0;
                i_ram_done    = 1'b0;
                i_ram_rd_data = '0;
                repeat (8) @(posedge i_clk);
                i_reset <= 1'b0;
                @(negedge i_clk);
                check_value("reset fetch valid", 0, o_fetch_valid);
                check_value("reset busy", 0, o_busy);
                check_value("reset ram read", 0, o_ram_rd_en);
                for (int n = 0; n < REQ_COUNT; n++)
                begin
                        @(posedge i_clk);
                        r = int'($urandom % 16);
                        if (r == 0)
                        begin
                                model_en = !model_en;   // Toggle at an idle point.
                                i_cache_en <= model_en;
                                @(posedge i_clk);
                        end
                        else if (r == 1)
                        begin
                                i_cache_inv <= 1'b1;
                                for (int i = 0; i < LINE_COUNT; i++)
                                        model_valid[i] = 1'b0;
                                @(posedge i_clk);
                                i_cache_inv <= 1'b0;
                        end
                        // 64 lines over 16 sets.
                        addr = addr_t'(($urandom % 256) * 4);
                        run_request(addr);
                end
                @(posedge i_clk);
                if (errors == 0)
                        $display("Testbench passed");
                else
                        $display("Testbench failed");
                $finish;
        end

endmodule

/* src/icache_fill_ctrl.sv */
`timescale 1ns/1ns

module icache_fill_ctrl
        import icache_geom_pkg::*, icache_fsm_pkg::*;
(
        input  logic    i_clk,                  // Clock.
        input  logic    i_reset,                // Sync reset.
        input  logic    i_fetch_valid,          // Request strobe.
        input  addr_t   i_fetch_addr,           // Word aligned request.
        input  logic    i_cache_en,             // Cache enable level.
        input  logic    i_hit,                  // From tag store.
        input  word_t   i_cached_word,          // From line store.
        input  logic    i_ram_done,             // RAM answer strobe.
        input  word_t   i_ram_rd_data,          // RAM answer data.
        output addr_t   o_rd_addr,              // Read address to both stores.
        output logic    o_wr_en,                // Write to both stores.
        output addr_t   o_wr_addr,
        output line_t   o_wr_line,
        output logic    o_fetch_valid,          // Response strobe.
        output word_t   o_fetch_data,
        output logic    o_busy,                 // Requester must wait.
        output logic    o_ram_rd_en,            // Held until done.
        output addr_t   o_ram_address
);

        // --------------------
        // Registers
        // --------------------
        fill_state_t    state_q;
        logic           look_valid_q;           // Request in lookup stage.
        addr_t          look_addr_q;
        logic           pend_valid_q;           // Request strobed as a miss began.
        addr_t          pend_addr_q;
        addr_t          miss_addr_q;            // Held miss address.
        word_sel_t      fill_word_q;            // Word being read.
        logic           line_full_q;            // All four words in.
        word_t          fill_buf_q [3];         // Words 0 to 2.
        word_t          resp_word_q;            // Last RAM word, then response.

        logic           lookup_hit;
        logic           miss_start;
        logic           respond_pend;
        logic           ram_ack;
        logic           req_valid;
        addr_t          req_addr;

        assign lookup_hit   = (state_q == ST_IDLE) && look_valid_q && i_cache_en && i_hit;
        assign miss_start   = (state_q == ST_IDLE) && look_valid_q && !lookup_hit;
        assign respond_pend = (state_q == ST_RESPOND) && pend_valid_q;
        assign ram_ack      = o_ram_rd_en && i_ram_done;

        // A parked request is looked up again once the fill is done.
        assign req_valid = i_fetch_valid || respond_pend;
        assign req_addr  = respond_pend ? pend_addr_q : i_fetch_addr;

        // Hold the miss address while the stores are being filled.
        assign o_rd_addr = (state_q == ST_FILL || state_q == ST_UNCACHED) ?
                           miss_addr_q : req_addr;

        // --------------------
        // RAM side
        // --------------------
        always_comb
        begin
                o_ram_rd_en   = 1'b0;
                o_ram_address = miss_addr_q;
                case (state_q)
                ST_IDLE:
                begin
                        o_ram_rd_en = miss_start;       // First read from T+1.
                        if (i_cache_en)
                                o_ram_address = word_addr(look_addr_q, FIRST_FILL_WORD);
                        else
                                o_ram_address = look_addr_q;
                end
                ST_FILL:
                begin
                        o_ram_rd_en   = !line_full_q;   // Quiet in the write cycle.
                        o_ram_address = word_addr(miss_addr_q, fill_word_q);
                end
                ST_UNCACHED:
                begin
                        o_ram_rd_en = 1'b1;
                end
                default:
                begin
                        o_ram_rd_en = 1'b0;
                end
                endcase
        end

        // --------------------
        // Store writes
        // --------------------
        assign o_wr_en   = (state_q == ST_FILL) && line_full_q;
        assign o_wr_addr = miss_addr_q;
        assign o_wr_line = {resp_word_q, fill_buf_q[2], fill_buf_q[1], fill_buf_q[0]};

        // Core side.
        assign o_fetch_valid = lookup_hit || (state_q == ST_RESPOND);
        assign o_fetch_data  = (state_q == ST_RESPOND) ? resp_word_q : i_cached_word;
        assign o_busy        = miss_start || (state_q == ST_FILL) ||
                               (state_q == ST_UNCACHED);

        // --------------------
        // Control state
        // --------------------
        always_ff @(posedge i_clk)
        begin
                if (i_reset)
                begin
                        state_q      <= ST_IDLE;
                        look_valid_q <= 1'b0;
                        pend_valid_q <= 1'b0;
                        fill_word_q  <= FIRST_FILL_WORD;
                        line_full_q  <= 1'b0;
                end
                else
                begin
                        case (state_q)
                        ST_IDLE:
                        begin
                                if (miss_start)
                                begin
                                        look_valid_q <= 1'b0;
                                        pend_valid_q <= i_fetch_valid; // Park it.
                                        fill_word_q  <= FIRST_FILL_WORD;
                                        line_full_q  <= 1'b0;
                                        state_q      <= i_cache_en ? ST_FILL : ST_UNCACHED;
                                end
                                else
                                begin
                                        look_valid_q <= i_fetch_valid;
                                end
                        end
                        ST_FILL:
                        begin
                                if (line_full_q)
                                        state_q <= ST_RESPOND;  // Write done this cycle.
                                else if (ram_ack)
                                begin
                                        if (fill_word_q == LAST_FILL_WORD)
                                                line_full_q <= 1'b1;
                                        else
                                                fill_word_q <= fill_word_q + 2'd1;
                                end
                        end
                        ST_UNCACHED:
                        begin
                                if (ram_ack)
                                        state_q <= ST_RESPOND;
                        end
                        ST_RESPOND:
                        begin
                                look_valid_q <= req_valid;
                                pend_valid_q <= 1'b0;
                                state_q      <= ST_IDLE;
                        end
                        default:
                        begin
                                state_q <= ST_IDLE;
                        end
                        endcase
                end
        end

        // --------------------
        // Address and data
        // --------------------
        always_ff @(posedge i_clk)
        begin
                if (state_q == ST_RESPOND)
                        look_addr_q <= req_addr;
                else if (state_q == ST_IDLE && !miss_start)
                        look_addr_q <= i_fetch_addr;

                if (miss_start)
                begin
                        miss_addr_q <= look_addr_q;
                        pend_addr_q <= i_fetch_addr;
                end

                if (ram_ack)
                begin
                        resp_word_q <= i_ram_rd_data;   // Word 3 or uncached word.
                        if (state_q == ST_FILL && fill_word_q != LAST_FILL_WORD)
                                fill_buf_q[fill_word_q] <= i_ram_rd_data;
                end

                // Pick the requested word out of the new line.
                if (o_wr_en)
                        resp_word_q <= line_word(o_wr_line, word_sel(miss_addr_q));
        end

endmodule

/* src/icache_fsm_pkg.sv */
package icache_fsm_pkg;

        import icache_geom_pkg::*;

        // --------------------
        // Controller states
        // --------------------
        typedef enum logic [1:0]
        {
                ST_IDLE,        // Lookup stage and hit response.
                ST_FILL,        // Four word line fill, then write.
                ST_UNCACHED,    // Single word read, cache off.
                ST_RESPOND      // Return the buffered word.
        } fill_state_t;

        // --------------------
        // Line fill order
        // --------------------

        // Fill always starts at word 0 of the line.
        localparam word_sel_t FIRST_FILL_WORD = 2'd0;

        // Done on this word ends the fill.
        localparam word_sel_t LAST_FILL_WORD  = 2'd3;

endpackage

/* src/icache_geom_pkg.sv */
package icache_geom_pkg;

        // --------------------
        // Cache geometry
        // --------------------
        localparam int WORD_BITS      = 32;                 // Instruction word.
        localparam int WORDS_PER_LINE = 4;                  // Words per line.
        localparam int LINE_BYTES     = 16;                 // Bytes per line.
        localparam int LINE_OFF_BITS  = $clog2(LINE_BYTES); // Byte offset field.

        typedef logic [31:0]                         addr_t;     // Byte address.
        typedef logic [WORD_BITS-1:0]                word_t;     // One fetched word.
        typedef logic [WORDS_PER_LINE*WORD_BITS-1:0] line_t;     // Word 0 in low bits.
        typedef logic [1:0]                          word_sel_t; // Address bits 3:2.

        // --------------------
        // Field helpers
        // --------------------

        // Clear the byte offset.
        function automatic addr_t line_base(input addr_t addr);
                return addr & ~addr_t'(LINE_BYTES - 1);
        endfunction

        function automatic word_sel_t word_sel(input addr_t addr);
                return addr[LINE_OFF_BITS-1:2]; // Word within the line.
        endfunction

        // Address of word w in the line holding addr.
        function automatic addr_t word_addr(input addr_t addr, input word_sel_t w);
                return line_base(addr) | addr_t'({w, 2'b00});
        endfunction

        // Shift the line down by the word offset.
        function automatic word_t line_word(input line_t line, input word_sel_t w);
                return line[w * WORD_BITS +: WORD_BITS];
        endfunction

endpackage

/* src/icache_line_store.sv */
`timescale 1ns/1ns

module icache_line_store
        import icache_geom_pkg::*;
#(
        parameter int LINE_COUNT = 16           // Power of two, at least 2.
)
(
        input  logic    i_clk,                  // Clock.
        input  addr_t   i_rd_addr,              // Lookup address.
        input  logic    i_wr_en,                // Whole line write.
        input  addr_t   i_wr_addr,              // Filled line address.
        input  line_t   i_wr_line,              // Filled line data.
        output word_t   o_rd_word               // Word at the lookup address.
);

        localparam int IDX_W = $clog2(LINE_COUNT);

        typedef logic [IDX_W-1:0] index_t;

        line_t          line_mem [LINE_COUNT];  // Line data array.

        index_t         rd_idx;
        index_t         wr_idx;

        line_t          rd_line_q;              // Line at the read index.
        word_sel_t      rd_sel_q;               // Word offset kept alongside.

        assign rd_idx = i_rd_addr[LINE_OFF_BITS +: IDX_W];
        assign wr_idx = i_wr_addr[LINE_OFF_BITS +: IDX_W];

        // --------------------
        // Array
        // --------------------
        always_ff @(posedge i_clk)
        begin
                if (i_wr_en)
                        line_mem[wr_idx] <= i_wr_line;  // All four words.
        end

        // Read lands one cycle after the address.
        always_ff @(posedge i_clk)
        begin
                rd_line_q <= line_mem[rd_idx];
                rd_sel_q  <= word_sel(i_rd_addr);
        end

        // Word select by offset.
        assign o_rd_word = line_word(rd_line_q, rd_sel_q);

endmodule

/* src/icache_tag_store.sv */
`timescale 1ns/1ns

module icache_tag_store
        import icache_geom_pkg::*;
#(
        parameter int LINE_COUNT = 16           // Power of two, at least 2.
)
(
        input  logic    i_clk,                  // Clock.
        input  logic    i_reset,                // Sync reset.
        input  addr_t   i_rd_addr,              // Lookup address.
        input  logic    i_wr_en,                // Store tag, set valid.
        input  addr_t   i_wr_addr,              // Filled line address.
        input  logic    i_inv,                  // Drop every line.
        output logic    o_hit                   // Valid and tag match.
);

        localparam int IDX_W = $clog2(LINE_COUNT);
        localparam int TAG_W = $bits(addr_t) - LINE_OFF_BITS - IDX_W;

        typedef logic [IDX_W-1:0] index_t;
        typedef logic [TAG_W-1:0] tag_t;

        tag_t                   tag_mem [LINE_COUNT];   // Tag per line.
        logic [LINE_COUNT-1:0]  valid_q;                // Valid per line.

        index_t rd_idx;
        index_t wr_idx;
        tag_t   rd_tag;
        tag_t   wr_tag;

        tag_t   stored_tag_q;           // Tag at the read index.
        logic   stored_valid_q;         // Valid at the read index.
        tag_t   req_tag_q;              // Tag of the lookup address.

        assign rd_idx = i_rd_addr[LINE_OFF_BITS +: IDX_W];
        assign rd_tag = i_rd_addr[LINE_OFF_BITS + IDX_W +: TAG_W];
        assign wr_idx = i_wr_addr[LINE_OFF_BITS +: IDX_W];
        assign wr_tag = i_wr_addr[LINE_OFF_BITS + IDX_W +: TAG_W];

        // --------------------
        // Valid vector
        // --------------------
        always_ff @(posedge i_clk)
        begin
                if (i_reset || i_inv)
                        valid_q <= '0;                  // Bulk clear.
                else if (i_wr_en)
                        valid_q[wr_idx] <= 1'b1;
        end

        always_ff @(posedge i_clk)
        begin
                if (i_wr_en)
                        tag_mem[wr_idx] <= wr_tag;
                stored_tag_q <= tag_mem[rd_idx];        // Registered read.
                req_tag_q    <= rd_tag;
        end

        // Invalidate also kills a read taken in the same cycle.
        always_ff @(posedge i_clk)
        begin
                if (i_reset)
                        stored_valid_q <= 1'b0;
                else
                        stored_valid_q <= valid_q[rd_idx] && !i_inv;
        end

        assign o_hit = stored_valid_q && (stored_tag_q == req_tag_q);

endmodule

/* src/icache_top.sv */
`timescale 1ns/1ns

module icache_top
        import icache_geom_pkg::*;
#(
        parameter int LINE_COUNT = 16           // Power of two, at least 2.
)
(
        input  logic    i_clk,                  // Clock.
        input  logic    i_reset,                // Sync reset.
        input  logic    i_fetch_valid,          // Request strobe.
        input  addr_t   i_fetch_addr,           // Word aligned.
        input  logic    i_cache_en,             // Cache enable level.
        input  logic    i_cache_inv,            // Invalidate all strobe.
        input  logic    i_ram_done,             // RAM answer strobe.
        input  word_t   i_ram_rd_data,          // RAM answer data.
        output logic    o_fetch_valid,          // Response strobe.
        output word_t   o_fetch_data,
        output logic    o_busy,
        output logic    o_ram_rd_en,
        output addr_t   o_ram_address
);

        // --------------------
        // Store connections
        // --------------------
        addr_t  rd_addr;                        // Shared read address.
        logic   wr_en;                          // Shared write strobe.
        addr_t  wr_addr;
        line_t  wr_line;
        logic   hit;
        word_t  cached_word;

        icache_tag_store #(.LINE_COUNT(LINE_COUNT)) u_tag_store (
                .i_clk          (i_clk),
                .i_reset        (i_reset),
                .i_rd_addr      (rd_addr),
                .i_wr_en        (wr_en),
                .i_wr_addr      (wr_addr),
                .i_inv          (i_cache_inv),
                .o_hit          (hit)
        );

        icache_line_store #(.LINE_COUNT(LINE_COUNT)) u_line_store (
                .i_clk          (i_clk),
                .i_rd_addr      (rd_addr),
                .i_wr_en        (wr_en),
                .i_wr_addr      (wr_addr),
                .i_wr_line      (wr_line),
                .o_rd_word      (cached_word)
        );

        // Lookup, fill and uncached reads.
        icache_fill_ctrl u_fill_ctrl (
                .i_clk          (i_clk),
                .i_reset        (i_reset),
                .i_fetch_valid  (i_fetch_valid),
                .i_fetch_addr   (i_fetch_addr),
                .i_cache_en     (i_cache_en),
                .i_hit          (hit),
                .i_cached_word  (cached_word),
                .i_ram_done     (i_ram_done),
                .i_ram_rd_data  (i_ram_rd_data),
                .o_rd_addr      (rd_addr),
                .o_wr_en        (wr_en),
                .o_wr_addr      (wr_addr),
                .o_wr_line      (wr_line),
                .o_fetch_valid  (o_fetch_valid),
                .o_fetch_data   (o_fetch_data),
                .o_busy         (o_busy),
                .o_ram_rd_en    (o_ram_rd_en),
                .o_ram_address  (o_ram_address)
        );

endmodule
